/* Makefile */
TOP := tb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ns --top-module $(TOP) -f tb.f

# build and run, pass only when the pass line shows up in the output
sim:
	verilator --binary --assert --timescale 1ns/1ns --top-module $(TOP) -f tb.f
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

/* logic/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
    input  wire alu_op_e op,
    input  wire word_t   a,
    input  wire word_t   b,
    // shift amount comes from the instruction
    input  wire shamt_t  shamt,
    output word_t        y,
    output wire          zero
);

    always_comb begin
        case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_AND:  y = a & b;
            ALU_OR:   y = a | b;
            ALU_XOR:  y = a ^ b;
            // signed compare
            ALU_SLT:  y = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: y = {31'd0, a < b};
            // sll shifts rt, which arrives on b
            ALU_SLL:  y = b << shamt;
            ALU_LUI:  y = {b[15:0], 16'h0000};
            default:  y = 32'h0000_0000;
        endcase
    end

    // equality flag for beq/bne after a subtract
    assign zero = (y == 32'h0000_0000);

endmodule

`default_nettype wire

/* logic/control_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module control_unit import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire word_t instr,
    input  wire        alu_zero,
    ctrl_if.ctrl       ctrl
);

    seq_state_e state;
    seq_state_e state_nxt;
    opcode_t    opcode;
    funct_t     funct;
    // high from the first cycle after reset release
    logic       run;
    logic       writes_rf;
    logic       is_load;
    logic       is_store;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run   <= 1'b0;
            state <= S_FETCH;
        end else begin
            run   <= 1'b1;
            state <= state_nxt;
        end
    end

    // fetch waits for run so the first request goes out after reset
    always_comb begin
        case (state)
            S_FETCH: state_nxt = run ? S_EXEC : S_FETCH;
            S_EXEC:  state_nxt = is_load ? S_MEM : S_FETCH;
            default: state_nxt = S_FETCH;
        endcase
    end

    always_comb begin
        ctrl.alu_op      = ALU_ADD;
        ctrl.alu_src_imm = 1'b0;
        ctrl.imm_ext     = IMM_SIGN;
        ctrl.dst_is_rt   = 1'b0;
        ctrl.branch_ne   = 1'b0;
        ctrl.is_branch   = 1'b0;
        ctrl.is_jump     = 1'b0;
        writes_rf        = 1'b0;
        is_load          = 1'b0;
        is_store         = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                writes_rf = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLTU: ctrl.alu_op = ALU_SLTU;
                    FN_SLL:  ctrl.alu_op = ALU_SLL;
                    // unsupported funct, retire as a nop
                    default: writes_rf = 1'b0;
                endcase
            end
            OP_ADDIU, OP_LW, OP_SW: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.dst_is_rt   = 1'b1;
                writes_rf        = (opcode != OP_SW);
                is_load          = (opcode == OP_LW);
                is_store         = (opcode == OP_SW);
            end
            OP_ANDI, OP_ORI: begin
                ctrl.alu_op      = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm_ext     = IMM_ZERO;
                ctrl.dst_is_rt   = 1'b1;
                writes_rf        = 1'b1;
            end
            OP_LUI: begin
                ctrl.alu_op      = ALU_LUI;
                ctrl.alu_src_imm = 1'b1;
                ctrl.dst_is_rt   = 1'b1;
                writes_rf        = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                // compare by subtraction, zero flag decides
                ctrl.alu_op    = ALU_SUB;
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = (opcode == OP_BNE);
            end
            OP_J: ctrl.is_jump = 1'b1;
            default: ;
        endcase
    end

    assign ctrl.state     = state;
    assign ctrl.fetch_req = run && (state == S_FETCH);
    // writeback state is exec, or mem for loads
    assign ctrl.reg_write = writes_rf &&
                            ((state == S_EXEC && !is_load) || (state == S_MEM && is_load));
    assign ctrl.mem_read  = is_load && (state == S_EXEC);
    assign ctrl.mem_write = is_store && (state == S_EXEC);

    a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctrl.mem_read && ctrl.mem_write));

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {S_FETCH, S_EXEC, S_MEM});

    // branch decision needs a settled compare from the datapath
    a_branch_zero_known: assert property (@(posedge clk) disable iff (!rst_n)
        (ctrl.is_branch && state == S_EXEC) |-> !$isunknown(alu_zero));

endmodule

`default_nettype wire

/* logic/cpu_ctrl_pkg.sv */
`default_nettype none

package cpu_ctrl_pkg;

    // alu function select
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        // immediate into upper half
        ALU_LUI  = 4'd8
    } alu_op_e;

    // multicycle sequencer
    // fetch issues the sram read, exec decodes and retires,
    // mem only for loads
    typedef enum logic [1:0] {
        S_FETCH = 2'd0,
        S_EXEC  = 2'd1,
        S_MEM   = 2'd2
    } seq_state_e;

    // 16-bit immediate widening
    typedef enum logic {
        IMM_SIGN = 1'b0,
        IMM_ZERO = 1'b1
    } imm_ext_e;

    // next pc source
    typedef enum logic [1:0] {
        PC_SEQ    = 2'd0,
        PC_BRANCH = 2'd1,
        PC_JUMP   = 2'd2
    } pc_sel_e;

endpackage

`default_nettype wire

/* logic/cpu_isa_pkg.sv */
`default_nettype none

package cpu_isa_pkg;

    // one machine word, data or byte address
    typedef logic [31:0] word_t;
    // architectural register number
    typedef logic [4:0]  reg_idx_t;
    // instruction fields
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm_t;
    // per-byte write strobe on the sram ports
    typedef logic [3:0]  byte_en_t;

    // major opcodes, bits 31:26
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

    // function codes under OP_SPECIAL, bits 5:0
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_SLT  = 6'h2a;
    localparam funct_t FN_SLTU = 6'h2b;

    // boot vector, kseg1 uncached
    localparam word_t RESET_PC = 32'hbfc0_0000;

endpackage

`default_nettype wire

/* logic/ctrl_if.sv */
`timescale 1ns/1ns
`default_nettype none

// decoded control, control_unit to datapath
interface ctrl_if import cpu_ctrl_pkg::*; ();

    seq_state_e state;
    // sram fetch request, low until the core leaves reset
    logic       fetch_req;
    alu_op_e    alu_op;
    // b operand is the widened immediate
    logic       alu_src_imm;
    imm_ext_e   imm_ext;
    // destination is rt (i-type) rather than rd
    logic       dst_is_rt;
    // only high in the writeback state
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    // bne instead of beq
    logic       branch_ne;
    logic       is_branch;
    logic       is_jump;

    modport ctrl (
        output state, fetch_req, alu_op, alu_src_imm, imm_ext, dst_is_rt,
        output reg_write, mem_read, mem_write, branch_ne, is_branch, is_jump
    );

    modport dp (
        input state, fetch_req, alu_op, alu_src_imm, imm_ext, dst_is_rt,
        input reg_write, mem_read, mem_write, branch_ne, is_branch, is_jump
    );

endinterface

`default_nettype wire

/* logic/datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module datapath import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
    input  wire           clk,
    input  wire           rst_n,
    output wire           inst_sram_en,
    output wire byte_en_t inst_sram_wen,
    output wire word_t    inst_sram_addr,
    output wire word_t    inst_sram_wdata,
    input  wire word_t    inst_sram_rdata,
    output wire           data_sram_en,
    output wire byte_en_t data_sram_wen,
    output wire word_t    data_sram_addr,
    output wire word_t    data_sram_wdata,
    input  wire word_t    data_sram_rdata,
    output wire word_t    debug_wb_pc,
    output wire byte_en_t debug_wb_rf_wen,
    output wire reg_idx_t debug_wb_rf_wnum,
    output wire word_t    debug_wb_rf_wdata
);

    ctrl_if u_ctrl_if ();

    word_t       pc;
    word_t       ir;
    word_t       instr;
    word_t       pc_plus4;
    word_t       br_target;
    word_t       j_target;
    word_t       pc_next;
    word_t       imm_x;
    word_t       rd1;
    word_t       rd2;
    word_t       alu_b;
    word_t       alu_y;
    word_t       wb_data;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    reg_idx_t    wa;
    shamt_t      shamt;
    imm_t        imm;
    logic [25:0] jidx;
    logic        alu_zero;
    logic        taken;
    logic        retire;
    pc_sel_e     pc_sel;

    // sram data arrives in exec, later states use the captured copy
    assign instr = (u_ctrl_if.state == S_EXEC) ? inst_sram_rdata : ir;

    assign rs    = instr[25:21];
    assign rt    = instr[20:16];
    assign rd    = instr[15:11];
    assign shamt = instr[10:6];
    assign imm   = instr[15:0];
    assign jidx  = instr[25:0];

    always_ff @(posedge clk) begin
        if (u_ctrl_if.state == S_EXEC) begin
            ir <= inst_sram_rdata;
        end
    end

    control_unit u_control_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (instr),
        .alu_zero (alu_zero),
        .ctrl     (u_ctrl_if.ctrl)
    );

    // sign or zero widening of the immediate
    assign imm_x = (u_ctrl_if.imm_ext == IMM_ZERO) ? {16'h0000, imm} : {{16{imm[15]}}, imm};
    assign alu_b = u_ctrl_if.alu_src_imm ? imm_x : rd2;

    alu u_alu (
        .op    (u_ctrl_if.alu_op),
        .a     (rd1),
        .b     (alu_b),
        .shamt (shamt),
        .y     (alu_y),
        .zero  (alu_zero)
    );

    // loads write back from the sram in mem, all else from the alu
    assign wa      = u_ctrl_if.dst_is_rt ? rt : rd;
    assign wb_data = (u_ctrl_if.state == S_MEM) ? data_sram_rdata : alu_y;

    regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (rs),
        .ra2   (rt),
        .wa    (wa),
        .we    (u_ctrl_if.reg_write),
        .wd    (wb_data),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    // no delay slot, targets relative to pc+4
    assign pc_plus4  = pc + 32'd4;
    assign br_target = pc_plus4 + {imm_x[29:0], 2'b00};
    assign j_target  = {pc_plus4[31:28], jidx, 2'b00};
    // beq takes on equal, bne on not equal
    assign taken     = alu_zero ^ u_ctrl_if.branch_ne;

    always_comb begin
        if (u_ctrl_if.is_jump) begin
            pc_sel = PC_JUMP;
        end else if (u_ctrl_if.is_branch && taken) begin
            pc_sel = PC_BRANCH;
        end else begin
            pc_sel = PC_SEQ;
        end
    end

    always_comb begin
        case (pc_sel)
            PC_BRANCH: pc_next = br_target;
            PC_JUMP:   pc_next = j_target;
            default:   pc_next = pc_plus4;
        endcase
    end

    // last cycle of an instruction, lw retires one state later
    assign retire = (u_ctrl_if.state == S_EXEC && !u_ctrl_if.mem_read) ||
                    (u_ctrl_if.state == S_MEM);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (retire) begin
            pc <= pc_next;
        end
    end

    // instruction port is read only
    assign inst_sram_en    = u_ctrl_if.fetch_req;
    assign inst_sram_wen   = 4'h0;
    assign inst_sram_addr  = pc;
    assign inst_sram_wdata = 32'h0000_0000;

    // word accesses only, address is rs + offset
    assign data_sram_en    = u_ctrl_if.mem_read | u_ctrl_if.mem_write;
    assign data_sram_wen   = u_ctrl_if.mem_write ? 4'hf : 4'h0;
    assign data_sram_addr  = alu_y;
    assign data_sram_wdata = rd2;

    // trace only shows writes that land, r0 excluded
    assign debug_wb_pc       = pc;
    assign debug_wb_rf_wen   = (u_ctrl_if.reg_write && wa != 5'd0) ? 4'hf : 4'h0;
    assign debug_wb_rf_wnum  = wa;
    assign debug_wb_rf_wdata = wb_data;

    // targets are built from word offsets, so the pc stays aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* logic/mycpu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mycpu_top import cpu_isa_pkg::*; (
    input  wire           clk,
    input  wire           rst_n,

    // instruction sram, rdata one cycle after en
    output wire           inst_sram_en,
    output wire byte_en_t inst_sram_wen,
    output wire word_t    inst_sram_addr,
    output wire word_t    inst_sram_wdata,
    input  wire word_t    inst_sram_rdata,

    // data sram
    output wire           data_sram_en,
    output wire byte_en_t data_sram_wen,
    output wire word_t    data_sram_addr,
    output wire word_t    data_sram_wdata,
    input  wire word_t    data_sram_rdata,

    // writeback trace
    output wire word_t    debug_wb_pc,
    output wire byte_en_t debug_wb_rf_wen,
    output wire reg_idx_t debug_wb_rf_wnum,
    output wire word_t    debug_wb_rf_wdata
);

    datapath u_datapath (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_wen     (inst_sram_wen),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

`default_nettype wire

/* logic/regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module regfile import cpu_isa_pkg::*; (
    input  wire           clk,
    input  wire           rst_n,
    input  wire reg_idx_t ra1,
    input  wire reg_idx_t ra2,
    input  wire reg_idx_t wa,
    input  wire           we,
    input  wire word_t    wd,
    output wire word_t    rd1,
    output wire word_t    rd2
);

    word_t regs [32];

    // r0 never written so it stays at its reset zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'h0000_0000;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // asynchronous reads
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

    a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (ra1 != 5'd0 || rd1 == 32'h0) && (ra2 != 5'd0 || rd2 == 32'h0));

endmodule

`default_nettype wire

/* tb.f */
logic/cpu_isa_pkg.sv
logic/cpu_ctrl_pkg.sv
logic/ctrl_if.sv
logic/alu.sv
logic/regfile.sv
logic/control_unit.sv
logic/datapath.sv
logic/mycpu_top.sv
tb/tb_top.sv

/* tb/tb_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_top import cpu_isa_pkg::*; ();

    // what one golden-model instruction produced
    typedef enum logic [1:0] {
        EV_NONE,
        EV_REG,
        EV_STORE
    } event_e;

    logic     clk = 1'b0;
    logic     rst_n;
    word_t    inst_sram_rdata;
    word_t    data_sram_rdata;

    wire           inst_sram_en;
    wire byte_en_t inst_sram_wen;
    wire word_t    inst_sram_addr;
    wire word_t    inst_sram_wdata;
    wire           data_sram_en;
    wire byte_en_t data_sram_wen;
    wire word_t    data_sram_addr;
    wire word_t    data_sram_wdata;
    wire word_t    debug_wb_pc;
    wire byte_en_t debug_wb_rf_wen;
    wire reg_idx_t debug_wb_rf_wnum;
    wire word_t    debug_wb_rf_wdata;

    // sram contents seen by the DUT
    word_t imem [256];
    word_t dmem [256];
    // golden model state with its own copy of both memories
    word_t g_imem [256];
    word_t g_dmem [256];
    word_t g_regs [32];
    word_t g_pc;

    // last model event
    event_e   ev_kind;
    word_t    ev_pc;
    reg_idx_t ev_num;
    word_t    ev_data;
    word_t    ev_addr;

    int    prog_len;
    int    cycle_count = 0;
    int    cycle_limit = 0;
    word_t end_pc;
    logic  seen_release = 1'b0;
    logic  seen_fetch = 1'b0;
    logic  done = 1'b0;
    logic  missed;
    word_t lcg_state = 32'd68806;

    mycpu_top DUT (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_wen     (inst_sram_wen),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #10 clk = ~clk;

    // sram models return data one cycle after en
    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= imem[inst_sram_addr[9:2]];
        end
    end

    always @(posedge clk) begin
        if (data_sram_en) begin
            if (data_sram_wen == 4'hf) begin
                dmem[data_sram_addr[9:2]] <= data_sram_wdata;
            end
            data_sram_rdata <= dmem[data_sram_addr[9:2]];
        end
    end

    task automatic stop_failed();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(string name, word_t expected, word_t actual);
        $display("error at %0t ns: %s expected %h got %h", $time, name, expected, actual);
        stop_failed();
    endtask

    task automatic report_failure(string msg);
        $display("error at %0t ns: %s", $time, msg);
        stop_failed();
    endtask

    // lcg built from the upper halves of two steps
    function automatic word_t rand_word();
        word_t hi;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        hi = lcg_state;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {hi[31:16], lcg_state[31:16]};
    endfunction

    // instruction encoders
    function automatic word_t r_type(funct_t fn, int rs, int rt, int rd, shamt_t sh);
        return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], sh, fn};
    endfunction

    function automatic word_t i_type(opcode_t op, int rs, int rt, imm_t imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic word_t j_to(int slot);
        word_t target;
        target = RESET_PC + slot * 4;
        return {OP_J, target[27:2]};
    endfunction

    task automatic emit(word_t w);
        imem[prog_len[7:0]] = w;
        g_imem[prog_len[7:0]] = w;
        prog_len = prog_len + 1;
    endtask

    // lui then ori
    task automatic load_const(int rd, word_t value);
        emit(i_type(OP_LUI, 0, rd, value[31:16]));
        emit(i_type(OP_ORI, rd, rd, value[15:0]));
    endtask

    task automatic build_program();
        word_t a_val;
        word_t b_val;
        word_t neg_val;
        word_t rnd;
        word_t addr;
        a_val = rand_word();
        b_val = rand_word();
        neg_val = rand_word() | 32'h8000_0000;
        rnd = rand_word();
        for (int i = 0; i < 256; i++) begin
            // unused slots hold r0 writes that trace nothing
            addr = RESET_PC + i * 4;
            imem[i[7:0]] = i_type(OP_LUI, 0, 0, addr[15:0] ^ addr[31:16]);
            g_imem[i[7:0]] = imem[i[7:0]];
            addr = i * 4;
            dmem[i[7:0]] = (addr * 32'h9e37_79b9) ^ 32'h5a5a_5a5a;
            g_dmem[i[7:0]] = dmem[i[7:0]];
        end
        prog_len = 0;
        load_const(1, a_val);
        load_const(2, b_val);
        load_const(3, neg_val);
        // register ops
        emit(r_type(FN_ADDU, 1, 2, 4, 5'd0));
        emit(r_type(FN_SUBU, 1, 2, 5, 5'd0));
        emit(r_type(FN_AND, 1, 2, 6, 5'd0));
        emit(r_type(FN_OR, 1, 2, 7, 5'd0));
        emit(r_type(FN_XOR, 1, 2, 8, 5'd0));
        emit(r_type(FN_SLL, 0, 1, 9, rnd[4:0]));
        // r3 is negative so signed and unsigned disagree
        emit(r_type(FN_SLT, 3, 1, 11, 5'd0));
        emit(r_type(FN_SLTU, 3, 1, 12, 5'd0));
        emit(r_type(FN_SLT, 1, 3, 13, 5'd0));
        emit(r_type(FN_SLTU, 1, 3, 14, 5'd0));
        // immediates with bit 15 set show zero vs sign widening
        emit(i_type(OP_ANDI, 3, 15, rnd[31:16] | 16'h8000));
        emit(i_type(OP_ADDIU, 1, 16, rnd[20:5] | 16'h8000));
        // data base 0x100 and one negative offset
        emit(i_type(OP_ADDIU, 0, 10, 16'h0100));
        emit(i_type(OP_SW, 10, 1, 16'h0000));
        emit(i_type(OP_SW, 10, 2, 16'h0004));
        emit(i_type(OP_SW, 10, 3, 16'hfffc));
        emit(i_type(OP_LW, 10, 17, 16'h0004));
        emit(i_type(OP_LW, 10, 18, 16'h0000));
        emit(i_type(OP_LW, 10, 19, 16'hfffc));
        // untouched word still holds the fill pattern
        emit(i_type(OP_LW, 10, 27, 16'h0008));
        // r0 write must vanish before r0 is read on rs and rt
        emit(i_type(OP_ADDIU, 1, 0, 16'h0005));
        emit(r_type(FN_ADDU, 0, 1, 20, 5'd0));
        emit(r_type(FN_OR, 1, 0, 28, 5'd0));
        // each branch skips or runs the next write
        emit(i_type(OP_BEQ, 1, 1, 16'h0001));
        emit(i_type(OP_ADDIU, 0, 21, 16'h0001));
        emit(i_type(OP_BEQ, 1, 2, 16'h0001));
        emit(i_type(OP_ADDIU, 0, 22, 16'h0002));
        emit(i_type(OP_BNE, 1, 2, 16'h0001));
        emit(i_type(OP_ADDIU, 0, 23, 16'h0003));
        emit(i_type(OP_BNE, 1, 1, 16'h0001));
        emit(i_type(OP_ADDIU, 0, 24, 16'h0004));
        emit(j_to(prog_len + 2));
        emit(i_type(OP_ADDIU, 0, 25, 16'h0005));
        emit(i_type(OP_ADDIU, 0, 26, 16'h0006));
        // final self loop
        end_pc = RESET_PC + prog_len * 4;
        emit(j_to(prog_len));
        for (int i = 0; i < 32; i++) begin
            g_regs[i[4:0]] = 32'h0000_0000;
        end
        g_pc = RESET_PC;
        cycle_limit = 3 * prog_len + 20;
    endtask

    // golden model step of one instruction
    task automatic exec_one();
        word_t    ins;
        word_t    a;
        word_t    b;
        word_t    sx;
        word_t    res;
        word_t    addr;
        word_t    pc4;
        word_t    nxt;
        reg_idx_t dst;
        logic     wr;
        ins = g_imem[g_pc[9:2]];
        a = g_regs[ins[25:21]];
        b = g_regs[ins[20:16]];
        sx = {{16{ins[15]}}, ins[15:0]};
        addr = a + sx;
        pc4 = g_pc + 32'd4;
        nxt = pc4;
        dst = ins[20:16];
        wr = 1'b1;
        res = 32'h0000_0000;
        ev_kind = EV_NONE;
        ev_pc = g_pc;
        case (ins[31:26])
            OP_SPECIAL: begin
                dst = ins[15:11];
                case (ins[5:0])
                    FN_ADDU: res = a + b;
                    FN_SUBU: res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                    FN_SLL:  res = b << ins[10:6];
                    default: report_failure("test program holds an unknown function code");
                endcase
            end
            OP_ADDIU: res = a + sx;
            OP_ANDI:  res = a & {16'h0000, ins[15:0]};
            OP_ORI:   res = a | {16'h0000, ins[15:0]};
            OP_LUI:   res = {ins[15:0], 16'h0000};
            OP_LW:    res = g_dmem[addr[9:2]];
            OP_SW: begin
                wr = 1'b0;
                g_dmem[addr[9:2]] = b;
                ev_kind = EV_STORE;
                ev_addr = addr;
                ev_data = b;
            end
            OP_BEQ, OP_BNE: begin
                wr = 1'b0;
                // beq wants equal and bne wants different
                if ((a == b) == (ins[31:26] == OP_BEQ)) begin
                    nxt = pc4 + {sx[29:0], 2'b00};
                end
            end
            OP_J: begin
                wr = 1'b0;
                nxt = {pc4[31:28], ins[25:0], 2'b00};
            end
            default: report_failure("test program holds an unknown opcode");
        endcase
        // r0 writes leave no trace
        if (wr && dst != 5'd0) begin
            g_regs[dst] = res;
            ev_kind = EV_REG;
            ev_num = dst;
            ev_data = res;
        end
        g_pc = nxt;
    endtask

    task automatic advance_to_event();
        ev_kind = EV_NONE;
        while (ev_kind == EV_NONE) begin
            if (g_pc == end_pc) begin
                report_failure("DUT made a write after the model reached the final loop");
            end
            exec_one();
        end
    endtask

    // model runs on to the final loop and any write there was missed by the DUT
    task automatic drain_model(output logic lost);
        lost = 1'b0;
        while (g_pc != end_pc) begin
            exec_one();
            if (ev_kind != EV_NONE) begin
                lost = 1'b1;
            end
        end
    endtask

    task automatic expect_idle_ports();
        assert (!inst_sram_en) else report_mismatch("inst_sram_en", 32'h0, 32'h1);
        assert (!data_sram_en) else report_mismatch("data_sram_en", 32'h0, 32'h1);
        assert (inst_sram_wen == 4'h0)
            else report_mismatch("inst_sram_wen", 32'h0, {28'd0, inst_sram_wen});
        assert (data_sram_wen == 4'h0)
            else report_mismatch("data_sram_wen", 32'h0, {28'd0, data_sram_wen});
        assert (debug_wb_rf_wen == 4'h0)
            else report_mismatch("debug_wb_rf_wen", 32'h0, {28'd0, debug_wb_rf_wen});
    endtask

    task automatic compare_writeback();
        advance_to_event();
        assert (ev_kind == EV_REG)
            else report_failure("DUT traced a register write where the model stores");
        assert (debug_wb_rf_wen == 4'hf)
            else report_mismatch("debug_wb_rf_wen", 32'hf, {28'd0, debug_wb_rf_wen});
        assert (debug_wb_pc == ev_pc) else report_mismatch("debug_wb_pc", ev_pc, debug_wb_pc);
        assert (debug_wb_rf_wnum == ev_num)
            else report_mismatch("debug_wb_rf_wnum", {27'd0, ev_num}, {27'd0, debug_wb_rf_wnum});
        assert (debug_wb_rf_wdata == ev_data)
            else report_mismatch("debug_wb_rf_wdata", ev_data, debug_wb_rf_wdata);
    endtask

    task automatic compare_store();
        advance_to_event();
        assert (ev_kind == EV_STORE)
            else report_failure("DUT wrote data memory where the model writes a register");
        assert (data_sram_wen == 4'hf)
            else report_mismatch("data_sram_wen", 32'hf, {28'd0, data_sram_wen});
        assert (debug_wb_pc == ev_pc) else report_mismatch("debug_wb_pc", ev_pc, debug_wb_pc);
        assert (data_sram_addr == ev_addr)
            else report_mismatch("data_sram_addr", ev_addr, data_sram_addr);
        assert (data_sram_wdata == ev_data)
            else report_mismatch("data_sram_wdata", ev_data, data_sram_wdata);
    endtask

    // checks on the falling edge where outputs have settled
    always @(negedge clk) begin
        if (!done) begin
            cycle_count = cycle_count + 1;
            if (cycle_count > cycle_limit) begin
                report_failure($sformatf("program did not finish within %0d cycles",
                                         cycle_limit));
            end
            if (!rst_n || !seen_release) begin
                // reset and the first cycle after release
                expect_idle_ports();
                seen_release = rst_n;
            end else begin
                assert (inst_sram_wen == 4'h0)
                    else report_mismatch("inst_sram_wen", 32'h0, {28'd0, inst_sram_wen});
                assert (inst_sram_wdata == 32'h0000_0000)
                    else report_mismatch("inst_sram_wdata", 32'h0, inst_sram_wdata);
                if (inst_sram_en && !seen_fetch) begin
                    seen_fetch = 1'b1;
                    assert (inst_sram_addr == RESET_PC)
                        else report_mismatch("inst_sram_addr", RESET_PC, inst_sram_addr);
                end
                if (debug_wb_rf_wen != 4'h0) begin
                    compare_writeback();
                end
                if (data_sram_en && data_sram_wen != 4'h0) begin
                    compare_store();
                end
                if (inst_sram_en && inst_sram_addr == end_pc) begin
                    done = 1'b1;
                end
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        inst_sram_rdata = 32'h0000_0000;
        data_sram_rdata = 32'h0000_0000;
        build_program();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        wait (done);
        drain_model(missed);
        if (missed) begin
            report_failure("DUT reached the final loop without making every model write");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
